// ==== flist.f ====
rtl/page_comp_pkg.sv
rtl/line_stream_if.sv
rtl/page_line_buffer.sv
rtl/chunk_zero_detect.sv
rtl/page_comp_ctrl.sv
rtl/page_compressor_top.sv
sim/tb_page_compressor.sv

// ==== Makefile ====
TOP = tb_page_compressor
BIN = obj_dir/V$(TOP)
SRCS = $(wildcard rtl/*.sv) $(wildcard sim/*.sv)

.PHONY: all run clean

all: run

$(BIN): flist.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f flist.f

run: $(BIN)
	$(BIN) | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== sim/tb_page_compressor.sv ====
`timescale 1ns/1ps

module tb_page_compressor import page_comp_pkg::*; ();

	localparam int NUM_TESTS   = 15;
	localparam int WATCHDOG_NS = NUM_TESTS * LINES_PER_PAGE * 8 * 4;
	localparam int WAIT_LIMIT  = 2000;

	logic              clk_i;
	logic              rst_ni;
	logic              page_wr;
	logic [LINE_W-1:0] page_wr_data;
	logic              page_wr_err;
	logic              comp_start;
	logic              fifo_full;
	logic              wr_req;
	logic [LINE_W-1:0] wr_data;
	logic [SIZE_W-1:0] comp_size;
	logic              incompressible;
	logic              comp_done;
	logic              bus_error;

	integer seed;
	int     err_cnt;
	int     chk_cnt;
	logic   stall_en;

	// lines written into the buffer and lines seen on the write port
	logic [LINE_W-1:0] page_ref [LINES_PER_PAGE];
	logic [LINE_W-1:0] out_lines [$];

	page_compressor_top DUT (
		.clk_i          (clk_i),
		.rst_ni         (rst_ni),
		.page_wr        (page_wr),
		.page_wr_data   (page_wr_data),
		.page_wr_err    (page_wr_err),
		.comp_start     (comp_start),
		.fifo_full      (fifo_full),
		.wr_req         (wr_req),
		.wr_data        (wr_data),
		.comp_size      (comp_size),
		.incompressible (incompressible),
		.comp_done      (comp_done),
		.bus_error      (bus_error)
	);

	always #2 clk_i = ~clk_i;

	// random stall windows on the write FIFO
	always @(posedge clk_i) begin
		#1;
		if (!stall_en) begin
			fifo_full = 1'b0;
		end else if (fifo_full) begin
			fifo_full = ({$random(seed)} % 2) == 0;
		end else begin
			fifo_full = ({$random(seed)} % 4) == 0;
		end
	end

	task automatic check(input logic cond, input string what);
		chk_cnt++;
		assert (cond) else begin
			$display("[ERROR] %0t: %s", $time, what);
			err_cnt++;
		end
	endtask

	// output monitor sampled mid-cycle where wr_req and fifo_full are settled
	always @(negedge clk_i) begin
		if (rst_ni) begin
			assert (!(wr_req && fifo_full)) else begin
				$display("[ERROR] %0t: wr_req raised while fifo_full is high", $time);
				err_cnt++;
			end
			if (wr_req) begin
				out_lines.push_back(wr_data);
			end
		end
	end

	task automatic apply_reset();
		rst_ni = 1'b0;
		repeat (5) @(posedge clk_i);
		#1;
		rst_ni = 1'b1;
	endtask

	// zero chunks get zero lines and the rest random non-zero lines
	task automatic fill_page(input logic [NUM_CHUNKS-1:0] zmap, input int err_line);
		logic [LINE_W-1:0] line;
		for (int i = 0; i < LINES_PER_PAGE; i++) begin
			line = '0;
			if (!zmap[i / LINES_PER_CHUNK]) begin
				for (int w = 0; w < LINE_W / 32; w++) begin
					line[w*32 +: 32] = $random(seed);
				end
				line[0] = 1'b1;
			end
			page_ref[i] = line;
			@(posedge clk_i);
			#1;
			page_wr      = 1'b1;
			page_wr_data = line;
			page_wr_err  = (i == err_line);
		end
		@(posedge clk_i);
		#1;
		page_wr     = 1'b0;
		page_wr_err = 1'b0;
	endtask

	task automatic wait_outcome(output logic timed_out);
		int n;
		n = 0;
		timed_out = 1'b0;
		@(negedge clk_i);
		while (!(comp_done || incompressible || bus_error)) begin
			n++;
			if (n > WAIT_LIMIT) begin
				timed_out = 1'b1;
				break;
			end
			@(negedge clk_i);
		end
	endtask

	task automatic run_page(input logic [NUM_CHUNKS-1:0] zmap, input logic stalls);
		logic [NUM_CHUNKS-1:0] exp_zmap;
		int                    n_zero;
		int                    kept;
		logic                  exp_comp;
		int                    exp_size;
		int                    n_exp;
		int                    n;
		logic                  timed_out;
		out_line_u             first;

		fill_page(zmap, -1);

		// reference model from the written data
		exp_zmap = '1;
		for (int i = 0; i < LINES_PER_PAGE; i++) begin
			if (page_ref[i] != '0) begin
				exp_zmap[i / LINES_PER_CHUNK] = 1'b0;
			end
		end
		n_zero   = $countones(exp_zmap);
		exp_comp = (n_zero >= MIN_ZERO_CHUNKS);
		kept     = -1;
		for (int c = 0; c < NUM_CHUNKS; c++) begin
			if (!exp_zmap[c] && kept < 0) begin
				kept = c;
			end
		end
		n_exp    = (kept >= 0) ? 1 + LINES_PER_CHUNK : 1;
		// every output line is one cache line worth of bytes
		exp_size = n_exp * LINE_BYTES;

		out_lines.delete();
		stall_en = stalls;
		@(posedge clk_i);
		#1;
		comp_start = 1'b1;
		wait_outcome(timed_out);
		chk_cnt++;
		assert (!timed_out) else begin
			$display("page %b: no comp_done, incompressible or bus_error in %0d cycles",
				 zmap, WAIT_LIMIT);
			err_cnt++;
		end
		if (exp_comp && !timed_out) begin
			check(comp_done && !incompressible, $sformatf("page %b not compressed", zmap));
			check(out_lines.size() == n_exp,
			      $sformatf("page %b: %0d lines written, expected %0d",
					zmap, out_lines.size(), n_exp));
			if (out_lines.size() > 0) begin
				first.raw = out_lines[0];
				check(first.hdr.zero_map == exp_zmap,
				      $sformatf("header zero_map %b, expected %b",
						first.hdr.zero_map, exp_zmap));
				check(first.hdr.has_data == (kept >= 0),
				      $sformatf("header has_data %b for page %b", first.hdr.has_data, zmap));
				check(first.hdr.reserved == '0, "header reserved bits not zero");
				if (kept >= 0) begin
					check(first.hdr.kept_chunk == CHUNK_W'(kept),
					      $sformatf("header kept_chunk %0d, expected %0d",
							first.hdr.kept_chunk, kept));
				end
			end
			for (int k = 1; k < out_lines.size() && k <= LINES_PER_CHUNK; k++) begin
				check(out_lines[k] == page_ref[kept * LINES_PER_CHUNK + k - 1],
				      $sformatf("page %b: chunk line %0d differs", zmap, k - 1));
			end
			// done must hold while comp_start stays high
			repeat (6) begin
				@(negedge clk_i);
				check(comp_done, "comp_done fell while comp_start was held");
				check(comp_size == SIZE_W'(exp_size),
				      $sformatf("comp_size %0d, expected %0d", comp_size, exp_size));
			end
			check(out_lines.size() == n_exp, "wr_req seen after comp_done");
		end else if (!timed_out) begin
			check(incompressible && !comp_done,
			      $sformatf("page %b not flagged incompressible", zmap));
			@(negedge clk_i);
			check(!incompressible, "incompressible longer than one cycle");
			check(out_lines.size() == 0,
			      $sformatf("incompressible page %b wrote %0d lines", zmap, out_lines.size()));
		end

		@(posedge clk_i);
		#1;
		comp_start = 1'b0;
		n = 0;
		@(negedge clk_i);
		while (comp_done && n < 4) begin
			n++;
			@(negedge clk_i);
		end
		check(!comp_done, "comp_done did not fall after comp_start dropped");
		stall_en = 1'b0;
		repeat (4) @(posedge clk_i);
	endtask

	task automatic bus_error_test();
		logic timed_out;
		fill_page(4'b1101, 20);
		out_lines.delete();
		@(posedge clk_i);
		#1;
		comp_start = 1'b1;
		wait_outcome(timed_out);
		check(!timed_out && bus_error, "bus_error not raised for a line with page_wr_err");
		check(!comp_done, "comp_done raised together with bus_error");
		@(posedge clk_i);
		#1;
		comp_start = 1'b0;
		repeat (10) begin
			@(negedge clk_i);
			check(bus_error && !comp_done, "bus_error did not hold until reset");
		end
		check(out_lines.size() == 0, "wr_req seen on a page with a bus error");
		apply_reset();
		@(negedge clk_i);
		check(!bus_error, "bus_error still high after reset");
	endtask

	initial begin
		clk_i        = 1'b0;
		rst_ni       = 1'b0;
		page_wr      = 1'b0;
		page_wr_data = '0;
		page_wr_err  = 1'b0;
		comp_start   = 1'b0;
		fifo_full    = 1'b0;
		stall_en     = 1'b0;
		seed         = 32'h5829;
		err_cnt      = 0;
		chk_cnt      = 0;

		apply_reset();
		@(negedge clk_i);
		check(!wr_req && !comp_done && !incompressible && !bus_error,
		      "outputs not low after reset");
		check(!DUT.rd_req && !DUT.ld_rdptr, "read controls not low after reset");

		// one non-zero chunk in each position
		run_page(4'b1110, 1'b0);
		run_page(4'b1101, 1'b0);
		run_page(4'b1011, 1'b0);
		run_page(4'b0111, 1'b0);
		run_page(4'b1111, 1'b0);

		// incompressible pages, each followed by a good one
		run_page(4'b0000, 1'b0);
		run_page(4'b1011, 1'b0);
		run_page(4'b1010, 1'b0);
		run_page(4'b0111, 1'b0);

		// same pages under FIFO back-pressure
		run_page(4'b1110, 1'b1);
		run_page(4'b1101, 1'b1);
		run_page(4'b1011, 1'b1);
		run_page(4'b0111, 1'b1);
		run_page(4'b1111, 1'b1);

		bus_error_test();

		$display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("run did not finish within %0d ns, stopped by the watchdog", WATCHDOG_NS);
		$display("Checks failed");
		$finish;
	end

endmodule

// ==== rtl/page_compressor_top.sv ====
`timescale 1ns/1ps

module page_compressor_top import page_comp_pkg::*; (
	input  logic              clk_i,
	input  logic              rst_ni,

	// host fill port
	input  logic              page_wr,
	input  logic [LINE_W-1:0] page_wr_data,
	input  logic              page_wr_err,

	// compression handshake
	input  logic              comp_start,
	input  logic              fifo_full,
	output logic              wr_req,
	output logic [LINE_W-1:0] wr_data,
	output logic [SIZE_W-1:0] comp_size,
	output logic              incompressible,
	output logic              comp_done,
	output logic              bus_error
);

	logic                  page_clr;
	logic                  rd_req;
	logic                  ld_rdptr;
	logic [PTR_W-1:0]      rdptr;
	logic                  empty;
	logic                  det_clr;
	logic                  scan_en;
	logic [NUM_CHUNKS-1:0] zero_map;

	line_stream_if ls ();

	page_line_buffer u_buf (
		.clk_i        (clk_i),
		.rst_ni       (rst_ni),
		.page_wr      (page_wr),
		.page_wr_data (page_wr_data),
		.page_wr_err  (page_wr_err),
		.page_clr     (page_clr),
		.rd_req       (rd_req),
		.ld_rdptr     (ld_rdptr),
		.rdptr        (rdptr),
		.empty        (empty),
		.ls           (ls.src)
	);

	// one detector per chunk, all watching the same stream
	for (genvar g = 0; g < NUM_CHUNKS; g++) begin : g_det
		chunk_zero_detect #(
			.CHUNK_ID (g)
		) u_det (
			.clk_i      (clk_i),
			.rst_ni     (rst_ni),
			.clr        (det_clr),
			.scan_en    (scan_en),
			.ls         (ls.sink),
			.chunk_zero (zero_map[g])
		);
	end

	page_comp_ctrl u_ctrl (
		.clk_i          (clk_i),
		.rst_ni         (rst_ni),
		.comp_start     (comp_start),
		.empty          (empty),
		.fifo_full      (fifo_full),
		.zero_map       (zero_map),
		.ls             (ls.sink),
		.rd_req         (rd_req),
		.ld_rdptr       (ld_rdptr),
		.rdptr          (rdptr),
		.page_clr       (page_clr),
		.det_clr        (det_clr),
		.scan_en        (scan_en),
		.wr_req         (wr_req),
		.wr_data        (wr_data),
		.comp_size      (comp_size),
		.incompressible (incompressible),
		.comp_done      (comp_done),
		.bus_error      (bus_error)
	);

endmodule

// ==== rtl/page_comp_ctrl.sv ====
`timescale 1ns/1ps

module page_comp_ctrl import page_comp_pkg::*; (
	input  logic                  clk_i,
	input  logic                  rst_ni,

	input  logic                  comp_start,
	input  logic                  empty,
	input  logic                  fifo_full,
	input  logic [NUM_CHUNKS-1:0] zero_map,
	line_stream_if.sink           ls,

	output logic                  rd_req,
	output logic                  ld_rdptr,
	output logic [PTR_W-1:0]      rdptr,
	output logic                  page_clr,
	output logic                  det_clr,
	output logic                  scan_en,

	output logic                  wr_req,
	output logic [LINE_W-1:0]     wr_data,
	output logic [SIZE_W-1:0]     comp_size,
	output logic                  incompressible,
	output logic                  comp_done,
	output logic                  bus_error
);

	localparam int ZCNT_W = $clog2(NUM_CHUNKS + 1);

	logic [STATE_W-1:0] state_q;
	logic [STATE_W-1:0] state_d;

	// lines requested and lines received or written in the current pass
	logic [PTR_W:0]      req_cnt_q;
	logic [PTR_W:0]      rx_cnt_q;

	// single output slot shared by the header and the chunk lines
	out_line_u           out_q;
	logic                out_vld_q;

	out_line_u           hdr_line;
	logic [ZCNT_W-1:0]   zero_cnt;
	logic [CHUNK_W-1:0]  kept_idx;
	logic                compress;
	logic [SIZE_W-1:0]   size_d;
	logic [SIZE_W-1:0]   size_q;
	logic                incomp_q;
	logic                clr_q;

	// decision terms, sampled only in the decide state
	always_comb begin
		zero_cnt = '0;
		kept_idx = '0;
		// walk downwards so the lowest non-zero chunk wins
		for (int i = NUM_CHUNKS - 1; i >= 0; i--) begin
			zero_cnt = zero_cnt + ZCNT_W'(zero_map[i]);
			if (!zero_map[i]) begin
				kept_idx = CHUNK_W'(i);
			end
		end
		compress = (zero_cnt >= ZCNT_W'(MIN_ZERO_CHUNKS));

		hdr_line.raw            = '0;
		hdr_line.hdr.zero_map   = zero_map;
		hdr_line.hdr.kept_chunk = kept_idx;
		hdr_line.hdr.has_data   = (zero_cnt != ZCNT_W'(NUM_CHUNKS));

		// header line plus 16 lines per kept chunk
		size_d = SIZE_W'((1 + LINES_PER_CHUNK * (NUM_CHUNKS - zero_cnt)) * LINE_BYTES);
	end

	assign wr_req = out_vld_q && !fifo_full;

	always_comb begin
		rd_req = 1'b0;
		case (state_q)
			ST_SCAN: begin
				rd_req = !empty && (req_cnt_q < (PTR_W+1)'(LINES_PER_PAGE));
			end
			ST_XFER: begin
				// one line in flight at a time, so a stall never drops one
				rd_req = !empty && !fifo_full && !ls.valid &&
					 (req_cnt_q < (PTR_W+1)'(LINES_PER_CHUNK)) &&
					 (!out_vld_q || wr_req);
			end
			default: rd_req = 1'b0;
		endcase
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (comp_start && !empty) begin
					state_d = ST_SCAN;
				end
			end
			ST_SCAN: begin
				if (ls.valid && ls.err) begin
					state_d = ST_BUS_ERR;
				end else if (ls.valid &&
					     rx_cnt_q == (PTR_W+1)'(LINES_PER_PAGE - 1)) begin
					state_d = ST_DECIDE;
				end
			end
			ST_DECIDE: begin
				state_d = compress ? ST_WR_HDR : ST_IDLE;
			end
			ST_WR_HDR: begin
				if (wr_req) begin
					state_d = out_q.hdr.has_data ? ST_LOAD_PTR : ST_DONE;
				end
			end
			ST_LOAD_PTR: begin
				state_d = ST_XFER;
			end
			ST_XFER: begin
				if (ls.valid && ls.err) begin
					state_d = ST_BUS_ERR;
				end else if (wr_req &&
					     rx_cnt_q == (PTR_W+1)'(LINES_PER_CHUNK - 1)) begin
					state_d = ST_DONE;
				end
			end
			ST_DONE: begin
				// hold done until the host drops its request
				if (!comp_start) begin
					state_d = ST_IDLE;
				end
			end
			// only reset leaves the error state
			ST_BUS_ERR: state_d = ST_BUS_ERR;
			default:    state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q   <= ST_IDLE;
			req_cnt_q <= '0;
			rx_cnt_q  <= '0;
			out_vld_q <= 1'b0;
			incomp_q  <= 1'b0;
			clr_q     <= 1'b0;
		end else begin
			state_q  <= state_d;
			incomp_q <= (state_q == ST_DECIDE) && !compress;
			// one clear pulse at the end of every page
			clr_q    <= ((state_q == ST_DECIDE) && !compress) ||
				    ((state_d == ST_DONE) && (state_q != ST_DONE));

			case (state_q)
				ST_SCAN: begin
					if (rd_req) begin
						req_cnt_q <= req_cnt_q + 1'b1;
					end
					if (ls.valid) begin
						rx_cnt_q <= rx_cnt_q + 1'b1;
					end
				end
				ST_XFER: begin
					if (rd_req) begin
						req_cnt_q <= req_cnt_q + 1'b1;
					end
					if (wr_req) begin
						rx_cnt_q <= rx_cnt_q + 1'b1;
					end
				end
				ST_IDLE, ST_LOAD_PTR: begin
					req_cnt_q <= '0;
					rx_cnt_q  <= '0;
				end
				default: ;
			endcase

			if (state_q == ST_DECIDE && compress) begin
				out_vld_q <= 1'b1;
			end else if (state_q == ST_XFER && ls.valid && !ls.err) begin
				out_vld_q <= 1'b1;
			end else if (wr_req) begin
				out_vld_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (state_q == ST_DECIDE) begin
			out_q  <= hdr_line;
			size_q <= size_d;
		end else if (state_q == ST_XFER && ls.valid) begin
			out_q.raw <= ls.data;
		end
	end

	// header is still in the slot while the pointer loads
	assign rdptr    = {out_q.hdr.kept_chunk, {(PTR_W - CHUNK_W){1'b0}}};
	assign ld_rdptr = (state_q == ST_LOAD_PTR);
	assign det_clr  = (state_q == ST_IDLE) && comp_start && !empty;
	assign scan_en  = (state_q == ST_SCAN);
	assign page_clr = clr_q;

	assign wr_data        = out_q.raw;
	assign comp_size      = size_q;
	assign incompressible = incomp_q;
	assign comp_done      = (state_q == ST_DONE);
	assign bus_error      = (state_q == ST_BUS_ERR);

endmodule

// ==== rtl/chunk_zero_detect.sv ====
`timescale 1ns/1ps

module chunk_zero_detect import page_comp_pkg::*; #(
	parameter int CHUNK_ID = 0
) (
	input  logic         clk_i,
	input  logic         rst_ni,
	input  logic         clr,
	input  logic         scan_en,
	line_stream_if.sink  ls,
	output logic         chunk_zero
);

	localparam int CNT_W = $clog2(LINES_PER_CHUNK + 1);

	logic [CNT_W-1:0] line_cnt_q;
	logic [CNT_W-1:0] zero_cnt_q;
	logic             in_chunk;
	logic             hit;

	// upper index bits select the chunk
	assign in_chunk = (ls.idx[PTR_W-1 -: CHUNK_W] == CHUNK_W'(CHUNK_ID));
	assign hit      = scan_en && ls.valid && in_chunk;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			line_cnt_q <= '0;
			zero_cnt_q <= '0;
		end else if (clr) begin
			line_cnt_q <= '0;
			zero_cnt_q <= '0;
		end else if (hit) begin
			line_cnt_q <= line_cnt_q + 1'b1;
			if (ls.data == '0) begin
				zero_cnt_q <= zero_cnt_q + 1'b1;
			end
		end
	end

	// only a fully seen chunk can be reported as zero
	assign chunk_zero = (line_cnt_q == CNT_W'(LINES_PER_CHUNK)) &&
			    (zero_cnt_q == CNT_W'(LINES_PER_CHUNK));

endmodule

// ==== rtl/page_line_buffer.sv ====
`timescale 1ns/1ps

module page_line_buffer import page_comp_pkg::*; (
	input  logic              clk_i,
	input  logic              rst_ni,

	// host fill port
	input  logic              page_wr,
	input  logic [LINE_W-1:0] page_wr_data,
	input  logic              page_wr_err,
	input  logic              page_clr,

	// read control from the controller
	input  logic              rd_req,
	input  logic              ld_rdptr,
	input  logic [PTR_W-1:0]  rdptr,
	output logic              empty,

	line_stream_if.src        ls
);

	logic [LINE_W-1:0]         mem_q [LINES_PER_PAGE];
	logic [LINES_PER_PAGE-1:0] err_q;

	// one extra bit so a full page is not mistaken for an empty one
	logic [PTR_W:0] wr_ptr_q;
	logic [PTR_W:0] rd_ptr_q;

	logic full;
	logic wr_en;
	logic pop;

	assign full  = wr_ptr_q[PTR_W];
	assign empty = (rd_ptr_q == wr_ptr_q);
	assign wr_en = page_wr && !full;

	// a pointer load replaces the pop of that cycle
	assign pop = rd_req && !ld_rdptr && !empty;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
		end else if (page_clr) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (ld_rdptr) begin
				// reload inside the written page to re-read a chunk
				rd_ptr_q <= {1'b0, rdptr};
			end else if (pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (wr_en) begin
			mem_q[wr_ptr_q[PTR_W-1:0]] <= page_wr_data;
			err_q[wr_ptr_q[PTR_W-1:0]] <= page_wr_err;
		end
	end

	// popped line shows up on the stream one cycle later
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			ls.valid <= 1'b0;
		end else begin
			ls.valid <= pop;
		end
	end

	always_ff @(posedge clk_i) begin
		if (pop) begin
			ls.data <= mem_q[rd_ptr_q[PTR_W-1:0]];
			ls.err  <= err_q[rd_ptr_q[PTR_W-1:0]];
			ls.idx  <= rd_ptr_q[PTR_W-1:0];
		end
	end

endmodule

// ==== rtl/line_stream_if.sv ====
`timescale 1ns/1ps

interface line_stream_if import page_comp_pkg::*; ();

	// one strobe per line, no back-pressure
	logic              valid;
	logic [LINE_W-1:0] data;
	// error response stored with the line
	logic              err;
	// position of the line inside the page
	logic [PTR_W-1:0]  idx;

	modport src (
		output valid,
		output data,
		output err,
		output idx
	);

	modport sink (
		input valid,
		input data,
		input err,
		input idx
	);

endinterface

// ==== rtl/page_comp_pkg.sv ====
package page_comp_pkg;

	// line and page geometry
	localparam int LINE_W          = 512;
	localparam int LINE_BYTES      = 64;
	localparam int LINES_PER_PAGE  = 64;
	localparam int LINES_PER_CHUNK = 16;
	localparam int NUM_CHUNKS      = 4;
	localparam int PTR_W           = 6;
	localparam int CHUNK_W         = 2;

	// a page compresses when this many chunks are all zero
	localparam int MIN_ZERO_CHUNKS = 3;

	// comp_size is in bytes, at most 1088
	localparam int SIZE_W = 14;

	// controller state encoding
	localparam int STATE_W = 3;
	localparam logic [STATE_W-1:0] ST_IDLE     = 3'd0;
	localparam logic [STATE_W-1:0] ST_SCAN     = 3'd1;
	localparam logic [STATE_W-1:0] ST_DECIDE   = 3'd2;
	localparam logic [STATE_W-1:0] ST_WR_HDR   = 3'd3;
	localparam logic [STATE_W-1:0] ST_LOAD_PTR = 3'd4;
	localparam logic [STATE_W-1:0] ST_XFER     = 3'd5;
	localparam logic [STATE_W-1:0] ST_DONE     = 3'd6;
	localparam logic [STATE_W-1:0] ST_BUS_ERR  = 3'd7;

	// first output line of a compressed page
	// zero_map sits in the low bits, the remainder is reserved and zero
	typedef struct packed {
		logic [LINE_W-NUM_CHUNKS-CHUNK_W-2:0] reserved;
		logic                                 has_data;
		logic [CHUNK_W-1:0]                   kept_chunk;
		logic [NUM_CHUNKS-1:0]                zero_map;
	} comp_hdr_t;

	// an output line is either a header or a raw cache line
	typedef union packed {
		comp_hdr_t         hdr;
		logic [LINE_W-1:0] raw;
	} out_line_u;

endpackage
